// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = frame_display_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== color_plane.sv ====
`timescale 1ns/1ps

module color_plane #(
   parameter int ADDR_W = pixel_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              read_enable,
   input  logic [ADDR_W-1:0] read_address,
   input  logic              write_enable,
   input  logic [ADDR_W-1:0] write_address,
   input  logic              write_bit,
   output logic              pixel_out
);

   localparam int DEPTH = 2 ** ADDR_W;

   // one bit per pixel, image starts black
   logic mem [0:DEPTH-1] = '{default: 1'b0};

   // host port, may land at any point of the scan
   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[write_address] <= write_bit;
      end
   end

   // read port with registered output
   // a write to the address being read returns the old bit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_out <= 1'b0;
      end else if (read_enable) begin
         pixel_out <= mem[read_address];       // holds while not enabled
      end
   end

endmodule

// ==== frame_display_tb.sv ====
`timescale 1ns/1ps

module frame_display_tb;

   import video_timing_pkg::*;
   import pixel_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int MAX_CASES    = 64;
   localparam int N_SAMPLES    = 16;

   logic           clk;
   logic           rst_n;
   logic           pix_we;
   logic [X_W-1:0] pix_x;
   logic [Y_W-1:0] pix_y;
   rgb_t           pix_rgb;
   logic           de;
   logic           hsync;
   logic           vsync;
   rgb_t           rgb;

   logic [7:0] case_words [0:4*MAX_CASES-1];   // phase, x, y, colour per case
   rgb_t       ref_img [0:IMG_W*IMG_H-1];
   logic       sample_mark [0:IMG_W*IMG_H-1];
   logic [31:0] seed;
   int n_cases;
   int n_checks = 0;
   int n_errors = 0;
   int cycle_count = 0;
   int timeout_limit = 0;
   int mon_cycle = 0;
   int last_hfall = -1;
   int last_vfall = -1;
   int last_defall = -1;
   int col = 0;
   int line_idx = 0;
   int frame_num = 0;
   logic prev_hsync = 1'b1;
   logic prev_vsync = 1'b1;
   logic prev_de = 1'b0;

   tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   frame_display_top UUT (
      .clk (clk), .rst_n (rst_n),
      .pix_we (pix_we), .pix_x (pix_x), .pix_y (pix_y), .pix_rgb (pix_rgb),
      .de (de), .hsync (hsync), .vsync (vsync), .rgb (rgb)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h (frame %0d line %0d column %0d)",
                  name, actual, expected, frame_num, line_idx, col);
      end
   endtask

   task automatic check_idle_outputs();
      check_value("hsync", 32'(hsync), 32'd1);
      check_value("vsync", 32'(vsync), 32'd1);
      check_value("de", 32'(de), 32'd0);
      check_value("rgb", 32'(rgb), 32'd0);
   endtask

   // one write per cycle, the reference image follows every write
   task automatic apply_writes(input int phase);
      logic [X_W-1:0] wx;
      logic [Y_W-1:0] wy;
      rgb_t           wc;
      for (int i = 0; i < n_cases; i++) begin
         if (case_words[4*i] == 8'(phase)) begin
            wx = case_words[4*i+1][X_W-1:0];
            wy = case_words[4*i+2][Y_W-1:0];
            wc = case_words[4*i+3][2:0];
            @(posedge clk);
            pix_we  <= 1'b1;
            pix_x   <= wx;
            pix_y   <= wy;
            pix_rgb <= wc;
            ref_img[{wy, wx}] = wc;
         end
      end
      @(posedge clk);
      pix_we <= 1'b0;
   endtask

   // position comes from de runs and vsync falls, outputs are stable here
   always @(negedge clk) begin : monitor
      int addr;
      if (rst_n) begin
         mon_cycle++;
         if (!hsync && prev_hsync) begin
            if (last_hfall >= 0) begin
               check_value("hsync period", mon_cycle - last_hfall, H_TOTAL);
            end
            if (last_defall >= 0) begin
               check_value("hsync after de", mon_cycle - last_defall, H_FRONT);
               last_defall = -1;                  // blank lines have no de run
            end
            last_hfall = mon_cycle;
         end
         if (hsync && !prev_hsync && last_hfall >= 0) begin
            check_value("hsync pulse length", mon_cycle - last_hfall, H_SYNC);
         end
         if (!vsync && prev_vsync) begin
            check_value("active lines per frame", line_idx, V_ACTIVE);
            if (last_hfall >= 0) begin
               check_value("vsync after hsync", mon_cycle - last_hfall, H_SYNC + H_BACK);
            end
            line_idx  = 0;
            frame_num++;
            last_vfall = mon_cycle;
         end
         if (vsync && !prev_vsync && last_vfall >= 0) begin
            check_value("vsync pulse length", mon_cycle - last_vfall, V_SYNC * H_TOTAL);
         end
         if (de) begin
            if (col >= IMG_W) begin
               check_value("rgb border", 32'(rgb), 32'd0);    // aliased columns stay black
            end else if (frame_num >= 1 && line_idx < IMG_H) begin
               addr = line_idx * IMG_W + col;
               check_value("rgb", 32'(rgb), 32'(ref_img[addr]));
               if (frame_num == 2 && sample_mark[addr]) begin
                  check_value("rgb red", 32'(rgb[RED_BIT]), 32'(ref_img[addr][RED_BIT]));
                  check_value("rgb green", 32'(rgb[GREEN_BIT]), 32'(ref_img[addr][GREEN_BIT]));
                  check_value("rgb blue", 32'(rgb[BLUE_BIT]), 32'(ref_img[addr][BLUE_BIT]));
               end
            end
            col++;
         end else if (prev_de) begin
            check_value("de cycles per line", col, H_ACTIVE);
            col = 0;
            line_idx++;
            last_defall = mon_cycle;
         end
         prev_hsync = hsync;
         prev_vsync = vsync;
         prev_de    = de;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         $display("run timed out after %0d cycles before the second frame ended", cycle_count);
         $display("checks: %0d  errors: %0d", n_checks, n_errors);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      pix_we  = 1'b0;
      pix_x   = '0;
      pix_y   = '0;
      pix_rgb = '0;
      for (int i = 0; i < 4*MAX_CASES; i++) begin
         case_words[i] = 8'h00;
      end
      for (int i = 0; i < IMG_W*IMG_H; i++) begin
         ref_img[i]     = '0;
         sample_mark[i] = 1'b0;
      end
      $readmemh("pixel_cases.txt", case_words);
      n_cases = 0;
      while (n_cases < MAX_CASES && case_words[4*n_cases] != 8'h00) begin
         n_cases++;
      end
      timeout_limit = RESET_CYCLES + n_cases + 3 * H_TOTAL * V_TOTAL;
      seed = 32'heea8_1b57;
      for (int i = 0; i < N_SAMPLES; i++) begin
         seed = lcg_next(seed);
         sample_mark[{seed[30:24], seed[22:16]}] = 1'b1;   // line, column
      end

      repeat (RESET_CYCLES / 2) @(negedge clk);
      check_idle_outputs();                              // inside reset
      wait (rst_n);
      @(negedge clk);
      check_idle_outputs();                              // first cycle after reset

      apply_writes(1);
      while (!(frame_num == 1 && line_idx == V_ACTIVE)) begin
         @(posedge clk);
      end
      apply_writes(2);                                   // vertical blanking
      while (!(frame_num == 2 && line_idx == V_ACTIVE)) begin
         @(posedge clk);
      end

      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== frame_display_top.sv ====
`timescale 1ns/1ps

module frame_display_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pix_we,
   input  logic [pixel_pkg::X_W-1:0] pix_x,
   input  logic [pixel_pkg::Y_W-1:0] pix_y,
   input  pixel_pkg::rgb_t         pix_rgb,
   output logic                    de,
   output logic                    hsync,
   output logic                    vsync,
   output pixel_pkg::rgb_t         rgb
);

   import video_timing_pkg::*;
   import pixel_pkg::*;

   logic [COORD_W-1:0] scan_x;
   logic [COORD_W-1:0] scan_y;
   logic               scan_active;
   logic               scan_hsync;
   logic               scan_vsync;
   logic               read_enable;
   logic [ADDR_W-1:0]  read_address;
   rgb_t               plane_bits;

   wire [ADDR_W-1:0] write_address = {pix_y, pix_x};    // line * IMG_W + column

   video_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (H_FRONT),
      .H_SYNC   (H_SYNC),
      .H_BACK   (H_BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (V_FRONT),
      .V_SYNC   (V_SYNC),
      .V_BACK   (V_BACK)
   ) timing (
      .clk         (clk),
      .rst_n       (rst_n),
      .scan_x      (scan_x),
      .scan_y      (scan_y),
      .scan_active (scan_active),
      .scan_hsync  (scan_hsync),
      .scan_vsync  (scan_vsync)
   );

   pixel_fetch #(
      .IMG_W (IMG_W),
      .IMG_H (IMG_H)
   ) fetch (
      .clk          (clk),
      .rst_n        (rst_n),
      .scan_x       (scan_x),
      .scan_y       (scan_y),
      .scan_active  (scan_active),
      .scan_hsync   (scan_hsync),
      .scan_vsync   (scan_vsync),
      .plane_bits   (plane_bits),
      .read_enable  (read_enable),
      .read_address (read_address),
      .de           (de),
      .hsync        (hsync),
      .vsync        (vsync),
      .rgb          (rgb)
   );

   // one plane per colour bit, all read at the same address
   color_plane #(.ADDR_W(ADDR_W)) red_plane (
      .clk (clk), .rst_n (rst_n),
      .read_enable (read_enable), .read_address (read_address),
      .write_enable (pix_we), .write_address (write_address),
      .write_bit (pix_rgb[RED_BIT]), .pixel_out (plane_bits[RED_BIT])
   );

   color_plane #(.ADDR_W(ADDR_W)) green_plane (
      .clk (clk), .rst_n (rst_n),
      .read_enable (read_enable), .read_address (read_address),
      .write_enable (pix_we), .write_address (write_address),
      .write_bit (pix_rgb[GREEN_BIT]), .pixel_out (plane_bits[GREEN_BIT])
   );

   color_plane #(.ADDR_W(ADDR_W)) blue_plane (
      .clk (clk), .rst_n (rst_n),
      .read_enable (read_enable), .read_address (read_address),
      .write_enable (pix_we), .write_address (write_address),
      .write_bit (pix_rgb[BLUE_BIT]), .pixel_out (plane_bits[BLUE_BIT])
   );

endmodule

// ==== pixel_cases.txt ====
// columns: phase x y colour, all in hex, one pixel write per line
// phase 1 loads before the first checked frame, phase 2 in the blanking after it
1 00 00 7
1 7f 00 4
1 00 7f 2
1 7f 7f 1
1 01 00 5
1 1f 10 6
1 10 1f 3
1 05 05 1
1 40 40 7
1 41 40 2
1 3c 22 4
1 22 3c 6
1 63 0e 5
1 0e 63 3
1 7e 01 7
1 15 15 2
1 15 15 6
1 50 6a 1
1 2a 77 4
1 77 2a 5
2 00 00 3
2 7f 00 6
2 00 7f 3
2 40 40 5
2 1f 10 7
2 50 6a 0
2 33 33 2

// ==== pixel_fetch.sv ====
`timescale 1ns/1ps

module pixel_fetch #(
   parameter int IMG_W = pixel_pkg::IMG_W,
   parameter int IMG_H = pixel_pkg::IMG_H
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [video_timing_pkg::COORD_W-1:0] scan_x,
   input  logic [video_timing_pkg::COORD_W-1:0] scan_y,
   input  logic                                 scan_active,
   input  logic                                 scan_hsync,
   input  logic                                 scan_vsync,
   input  pixel_pkg::rgb_t                      plane_bits,
   output logic                                 read_enable,
   output logic [pixel_pkg::ADDR_W-1:0]         read_address,
   output logic                                 de,
   output logic                                 hsync,
   output logic                                 vsync,
   output pixel_pkg::rgb_t                      rgb
);

   import video_timing_pkg::*;

   localparam int X_W = $clog2(IMG_W);
   localparam int Y_W = $clog2(IMG_H);

   localparam logic [COORD_W-1:0] X_LIM = COORD_W'(IMG_W);
   localparam logic [COORD_W-1:0] Y_LIM = COORD_W'(IMG_H);

   logic in_image;
   logic active_d;
   logic in_image_d;
   logic hsync_d;
   logic vsync_d;

   // columns past the image are border and never touch the planes
   assign in_image     = scan_active && (scan_x < X_LIM) && (scan_y < Y_LIM);
   assign read_enable  = in_image;
   assign read_address = {scan_y[Y_W-1:0], scan_x[X_W-1:0]};   // line * IMG_W + column

   // stage 1 waits for the plane read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active_d   <= 1'b0;
         in_image_d <= 1'b0;
         hsync_d    <= ~SYNC_ACTIVE;
         vsync_d    <= ~SYNC_ACTIVE;
      end else begin
         active_d   <= scan_active;
         in_image_d <= in_image;
         hsync_d    <= scan_hsync;
         vsync_d    <= scan_vsync;
      end
   end

   // stage 2 output register, plane bits are valid this cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         de    <= 1'b0;
         hsync <= ~SYNC_ACTIVE;
         vsync <= ~SYNC_ACTIVE;
         rgb   <= '0;
      end else begin
         de    <= active_d;
         hsync <= hsync_d;
         vsync <= vsync_d;
         rgb   <= in_image_d ? plane_bits : '0;     // border and blanking stay black
      end
   end

endmodule

// ==== pixel_pkg.sv ====
package pixel_pkg;

   // stored image size in pixels
   localparam int IMG_W = 128;
   localparam int IMG_H = 128;

   localparam int X_W = $clog2(IMG_W);    // column bits of a pixel address
   localparam int Y_W = $clog2(IMG_H);    // line bits of a pixel address

   // plane address is line * IMG_W + column, so line bits sit on top
   localparam int ADDR_W = X_W + Y_W;

   // one bit per colour, red in the msb
   typedef logic [2:0] rgb_t;

   localparam int RED_BIT   = 2;
   localparam int GREEN_BIT = 1;
   localparam int BLUE_BIT  = 0;

endpackage

// ==== sources.f ====
video_timing_pkg.sv
pixel_pkg.sv
color_plane.sv
video_timing.sv
pixel_fetch.sv
frame_display_top.sv
tb_clock_gen.sv
frame_display_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;                          // release on a rising edge
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
   parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE,
   parameter int H_FRONT  = video_timing_pkg::H_FRONT,
   parameter int H_SYNC   = video_timing_pkg::H_SYNC,
   parameter int H_BACK   = video_timing_pkg::H_BACK,
   parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE,
   parameter int V_FRONT  = video_timing_pkg::V_FRONT,
   parameter int V_SYNC   = video_timing_pkg::V_SYNC,
   parameter int V_BACK   = video_timing_pkg::V_BACK
) (
   input  logic                                clk,
   input  logic                                rst_n,
   output logic [video_timing_pkg::COORD_W-1:0] scan_x,
   output logic [video_timing_pkg::COORD_W-1:0] scan_y,
   output logic                                scan_active,
   output logic                                scan_hsync,
   output logic                                scan_vsync
);

   import video_timing_pkg::*;

   localparam int H_PERIOD = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_PERIOD = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   localparam logic [COORD_W-1:0] H_LAST   = COORD_W'(H_PERIOD - 1);
   localparam logic [COORD_W-1:0] V_LAST   = COORD_W'(V_PERIOD - 1);
   localparam logic [COORD_W-1:0] H_VIS    = COORD_W'(H_ACTIVE);
   localparam logic [COORD_W-1:0] V_VIS    = COORD_W'(V_ACTIVE);
   localparam logic [COORD_W-1:0] HS_FIRST = COORD_W'(H_ACTIVE + H_FRONT);
   localparam logic [COORD_W-1:0] HS_LAST  = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC - 1);
   localparam logic [COORD_W-1:0] VS_FIRST = COORD_W'(V_ACTIVE + V_FRONT);
   localparam logic [COORD_W-1:0] VS_LAST  = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC - 1);

   logic [COORD_W-1:0] x_next;
   logic [COORD_W-1:0] y_next;

   // next scan position; line advances on the last column
   always_comb begin
      if (scan_x == H_LAST) begin
         x_next = '0;
         if (scan_y == V_LAST) begin
            y_next = '0;                      // frame wrap
         end else begin
            y_next = scan_y + 1'b1;
         end
      end else begin
         x_next = scan_x + 1'b1;
         y_next = scan_y;
      end
   end

   // flags decode the next position so they line up with the counters
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scan_x      <= '0;
         scan_y      <= '0;
         scan_active <= 1'b1;                 // position 0,0 is visible
         scan_hsync  <= ~SYNC_ACTIVE;
         scan_vsync  <= ~SYNC_ACTIVE;
      end else begin
         scan_x      <= x_next;
         scan_y      <= y_next;
         scan_active <= (x_next < H_VIS) && (y_next < V_VIS);
         scan_hsync  <= (x_next >= HS_FIRST && x_next <= HS_LAST) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
         scan_vsync  <= (y_next >= VS_FIRST && y_next <= VS_LAST) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      end
   end

endmodule

// ==== video_timing_pkg.sv ====
package video_timing_pkg;

   // horizontal timing in pixel clocks
   localparam int H_ACTIVE = 160;
   localparam int H_FRONT  = 8;
   localparam int H_SYNC   = 16;
   localparam int H_BACK   = 8;
   localparam int H_TOTAL  = 192;       // sum of the four above

   // vertical timing in lines
   localparam int V_ACTIVE = 128;
   localparam int V_FRONT  = 2;
   localparam int V_SYNC   = 3;
   localparam int V_BACK   = 3;
   localparam int V_TOTAL  = 136;       // sum of the four above

   // level of hsync and vsync while the pulse is on
   localparam logic SYNC_ACTIVE = 1'b0;

   // width of the column and line counters
   localparam int COORD_W = 8;

endpackage
